// ==== src/lsu_pkg.sv ====
// load/store unit shared types

`default_nettype none

package lsu_pkg;

  // one data word of the RAM
  typedef logic [63:0] dword_t;

  localparam int DWORD_BYTES = 8;
  localparam int DWORD_BITS  = 64;

  // access size, low two bits of funct3
  typedef enum logic [1:0] {
    WIDTH_B = 2'b00,
    WIDTH_H = 2'b01,
    WIDTH_W = 2'b10,
    WIDTH_D = 2'b11
  } width_e;

  // decoded view of funct3
  typedef struct packed {
    logic   is_unsigned;
    width_e width;
  } funct3_s;

  // raw code for range checks, fields for masking and extension
  typedef union packed {
    logic [2:0] raw;
    funct3_s    f;
  } funct3_u;

  // load codes, stores share the first four
  localparam logic [2:0] FUNCT3_LB  = 3'b000;
  localparam logic [2:0] FUNCT3_LH  = 3'b001;
  localparam logic [2:0] FUNCT3_LW  = 3'b010;
  localparam logic [2:0] FUNCT3_LD  = 3'b011;
  localparam logic [2:0] FUNCT3_LBU = 3'b100;
  localparam logic [2:0] FUNCT3_LHU = 3'b101;
  localparam logic [2:0] FUNCT3_LWU = 3'b110;

endpackage

`default_nettype wire

// ==== src/lsu_if.sv ====
// load/store unit internal buses

`default_nettype none
`timescale 1ns/1ps

// decoded request, decode to execute
interface acc_if
  import lsu_pkg::*;
#(
  parameter int ADDR_W = 8
) ();

  logic              req_valid;
  logic              is_write;
  logic              out_of_range;
  logic [ADDR_W-1:0] word_addr1;
  logic              needs_second;
  dword_t            wmask1;
  dword_t            wmask2;
  dword_t            wdata1;
  dword_t            wdata2;
  logic [5:0]        bit_offset;
  funct3_u           funct3;

  modport dec (
    output req_valid, is_write, out_of_range, word_addr1, needs_second,
    output wmask1, wmask2, wdata1, wdata2, bit_offset, funct3
  );

  modport exe (
    input req_valid, is_write, out_of_range, word_addr1, needs_second,
    input wmask1, wmask2, wdata1, wdata2, bit_offset, funct3
  );

endinterface

// raw read words, execute to result
interface rd_if
  import lsu_pkg::*;
();

  logic       rd_valid;
  dword_t     rdata1;
  dword_t     rdata2;
  logic [5:0] bit_offset;
  funct3_u    funct3;

  modport exe (output rd_valid, rdata1, rdata2, bit_offset, funct3);
  modport res (input rd_valid, rdata1, rdata2, bit_offset, funct3);

endinterface

`default_nettype wire

// ==== src/dword_ram.sv ====
// dword data RAM

`default_nettype none
`timescale 1ns/1ps

module dword_ram
  import lsu_pkg::*;
#(
  parameter int RAM_WORDS = 256,
  parameter int ADDR_W    = 8
) (
  input  wire logic                   clk,
  input  wire logic                   en_i,
  input  wire logic [DWORD_BYTES-1:0] we_i,
  input  wire logic [ADDR_W-1:0]      addr_i,
  input  wire dword_t                 wdata_i,
  output dword_t                      rdata_o
);

  dword_t mem [RAM_WORDS];

  // read returns the old word when the same cycle writes it
  always_ff @(posedge clk) begin
    if (en_i) begin
      for (int b = 0; b < DWORD_BYTES; b++) begin
        if (we_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== src/lsu_decode.sv ====
// load/store request decode

`default_nettype none
`timescale 1ns/1ps

module lsu_decode
  import lsu_pkg::*;
#(
  parameter logic [63:0] BASE_ADDR = 64'h8000_0000,
  parameter int          ADDR_W    = 8
) (
  input  wire logic        clk,
  input  wire logic        rst_i,
  input  wire logic        psel_i,
  input  wire logic        penable_i,
  input  wire logic        pwrite_i,
  input  wire logic [63:0] paddr_i,
  input  wire dword_t      pwdata_i,
  input  wire funct3_u     funct3_i,
  acc_if.dec               acc
);

  dword_t     rel_addr;
  dword_t     word_idx;
  dword_t     last_idx;
  dword_t     bit_mask;
  logic [2:0] byte_off;
  logic [5:0] bit_off;
  logic [6:0] bit_rem;
  logic [3:0] nbytes;
  logic       second;
  logic       code_ok;
  logic       setup;

  assign setup    = psel_i & ~penable_i;
  assign rel_addr = paddr_i - BASE_ADDR;
  assign word_idx = rel_addr >> 3;
  assign byte_off = rel_addr[2:0];
  assign bit_off  = {byte_off, 3'b000};
  assign bit_rem  = 7'(DWORD_BITS) - {1'b0, bit_off};
  assign nbytes   = 4'd1 << funct3_i.f.width;

  // spills into the next dword
  assign second   = ({1'b0, byte_off} + nbytes) > 4'(DWORD_BYTES);
  assign last_idx = word_idx + {63'd0, second};

  // stores only have the four signed codes
  assign code_ok = pwrite_i ? (funct3_i.raw <= FUNCT3_LD) : (funct3_i.raw <= FUNCT3_LWU);

  always_comb begin
    case (funct3_i.f.width)
      WIDTH_B: bit_mask = 64'h0000_0000_0000_00ff;
      WIDTH_H: bit_mask = 64'h0000_0000_0000_ffff;
      WIDTH_W: bit_mask = 64'h0000_0000_ffff_ffff;
      default: bit_mask = 64'hffff_ffff_ffff_ffff;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      acc.req_valid <= 1'b0;
    end else begin
      acc.req_valid <= setup;
    end
  end

  // bundle captured once per request on the setup edge
  always_ff @(posedge clk) begin
    if (setup) begin
      acc.is_write     <= pwrite_i;
      // below base wraps to a huge index and lands here too
      acc.out_of_range <= ((last_idx >> ADDR_W) != '0) || !code_ok;
      acc.word_addr1   <= word_idx[ADDR_W-1:0];
      acc.needs_second <= second;
      acc.wmask1       <= bit_mask << bit_off;
      acc.wmask2       <= second ? (bit_mask >> bit_rem) : '0;
      acc.wdata1       <= pwdata_i << bit_off;
      acc.wdata2       <= pwdata_i >> bit_rem;
      acc.bit_offset   <= bit_off;
      acc.funct3       <= funct3_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/lsu_execute.sv ====
// load/store access sequencer

`default_nettype none
`timescale 1ns/1ps

module lsu_execute
  import lsu_pkg::*;
#(
  parameter int RAM_WORDS = 256,
  parameter int ADDR_W    = 8
) (
  input  wire logic clk,
  input  wire logic rst_i,
  acc_if.exe        acc,
  rd_if.exe         rd,
  output logic      pready_o,
  output logic      pslverr_o
);

  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_ERR  = 3'd1;
  localparam logic [2:0] S_ACC1 = 3'd2;
  localparam logic [2:0] S_ACC2 = 3'd3;
  localparam logic [2:0] S_WAIT = 3'd4;
  localparam logic [2:0] S_RESP = 3'd5;

  logic [2:0]             state;
  logic                   is_write_q;
  logic                   second_q;
  logic [ADDR_W-1:0]      addr_q;
  dword_t                 wmask1_q;
  dword_t                 wmask2_q;
  dword_t                 wdata1_q;
  dword_t                 wdata2_q;
  logic [DWORD_BYTES-1:0] be1;
  logic [DWORD_BYTES-1:0] be2;

  logic                   ram_en;
  logic [DWORD_BYTES-1:0] ram_we;
  logic [ADDR_W-1:0]      ram_addr;
  dword_t                 ram_wdata;
  dword_t                 ram_rdata;

  // one bit per lane is enough, masks are byte granular
  always_comb begin
    for (int i = 0; i < DWORD_BYTES; i++) begin
      be1[i] = wmask1_q[8*i];
      be2[i] = wmask2_q[8*i];
    end
  end

  assign ram_en    = (state == S_ACC1) || (state == S_ACC2);
  assign ram_addr  = (state == S_ACC2) ? addr_q + 1'b1 : addr_q;
  assign ram_wdata = (state == S_ACC2) ? wdata2_q : wdata1_q;
  assign ram_we    = !is_write_q      ? '0  :
                     (state == S_ACC1) ? be1 :
                     (state == S_ACC2) ? be2 : '0;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state       <= S_IDLE;
      pready_o    <= 1'b0;
      pslverr_o   <= 1'b0;
      rd.rd_valid <= 1'b0;
    end else begin
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (acc.req_valid) begin
            state <= acc.out_of_range ? S_ERR : S_ACC1;
          end
        end
        S_ERR: begin
          pready_o  <= 1'b1;
          pslverr_o <= 1'b1;
          state     <= S_RESP;
        end
        S_ACC1: state <= second_q ? S_ACC2 : S_WAIT;
        S_ACC2: state <= S_WAIT;
        S_WAIT: begin
          pready_o    <= 1'b1;
          rd.rd_valid <= !is_write_q;
          state       <= S_RESP;
        end
        // pready_o is high for this one cycle
        S_RESP: begin
          rd.rd_valid <= 1'b0;
          state       <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && acc.req_valid) begin
      is_write_q    <= acc.is_write;
      second_q      <= acc.needs_second;
      addr_q        <= acc.word_addr1;
      wmask1_q      <= acc.wmask1;
      wmask2_q      <= acc.wmask2;
      wdata1_q      <= acc.wdata1;
      wdata2_q      <= acc.wdata2;
      rd.bit_offset <= acc.bit_offset;
      rd.funct3     <= acc.funct3;
    end
    // first word arrives while the second is issued
    if (state == S_ACC2) begin
      rd.rdata1 <= ram_rdata;
    end
    if (state == S_WAIT) begin
      if (second_q) begin
        rd.rdata2 <= ram_rdata;
      end else begin
        rd.rdata1 <= ram_rdata;
        rd.rdata2 <= '0;
      end
    end
  end

  dword_ram #(
    .RAM_WORDS (RAM_WORDS),
    .ADDR_W    (ADDR_W)
  ) u_ram (
    .clk     (clk),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== src/lsu_result.sv ====
// load data merge and extension

`default_nettype none
`timescale 1ns/1ps

module lsu_result
  import lsu_pkg::*;
(
  rd_if.res      rd,
  output dword_t prdata_o
);

  dword_t     merged;
  logic [6:0] bit_rem;
  logic       sx;

  // shift by 64 yields zero, so an aligned access ignores rdata2
  assign bit_rem = 7'(DWORD_BITS) - {1'b0, rd.bit_offset};
  assign merged  = (rd.rdata1 >> rd.bit_offset) | (rd.rdata2 << bit_rem);

  // sign fill only for the signed loads
  assign sx = ~rd.funct3.f.is_unsigned;

  always_comb begin
    prdata_o = '0;
    if (rd.rd_valid && rd.funct3.raw <= FUNCT3_LWU) begin
      case (rd.funct3.f.width)
        WIDTH_B: begin
          prdata_o = {{56{sx & merged[7]}}, merged[7:0]};
        end
        WIDTH_H: begin
          prdata_o = {{48{sx & merged[15]}}, merged[15:0]};
        end
        WIDTH_W: begin
          prdata_o = {{32{sx & merged[31]}}, merged[31:0]};
        end
        WIDTH_D: begin
          prdata_o = merged;
        end
        default: begin
          prdata_o = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
// load/store unit with APB port

`default_nettype none
`timescale 1ns/1ps

module lsu_top
  import lsu_pkg::*;
#(
  parameter logic [63:0] BASE_ADDR = 64'h8000_0000,
  parameter int          RAM_WORDS = 256
) (
  input  wire logic        clk,
  input  wire logic        rst_i,
  input  wire logic        psel_i,
  input  wire logic        penable_i,
  input  wire logic        pwrite_i,
  input  wire logic [63:0] paddr_i,
  input  wire dword_t      pwdata_i,
  input  wire logic [2:0]  funct3_i,
  output dword_t           prdata_o,
  output logic             pready_o,
  output logic             pslverr_o
);

  // RAM_WORDS is expected to be a power of two
  localparam int ADDR_W = $clog2(RAM_WORDS);

  acc_if #(.ADDR_W(ADDR_W)) acc ();
  rd_if                     rd ();

  lsu_decode #(
    .BASE_ADDR (BASE_ADDR),
    .ADDR_W    (ADDR_W)
  ) u_decode (
    .clk       (clk),
    .rst_i     (rst_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .funct3_i  (funct3_i),
    .acc       (acc.dec)
  );

  lsu_execute #(
    .RAM_WORDS (RAM_WORDS),
    .ADDR_W    (ADDR_W)
  ) u_execute (
    .clk       (clk),
    .rst_i     (rst_i),
    .acc       (acc.exe),
    .rd        (rd.exe),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  lsu_result u_result (
    .rd       (rd.res),
    .prdata_o (prdata_o)
  );

endmodule

`default_nettype wire

// ==== test/lsu_top_chk.sv ====
// APB response checks

`default_nettype none
`timescale 1ns/1ps

module lsu_top_chk (
  input wire logic clk,
  input wire logic rst_i,
  input wire logic psel_i,
  input wire logic penable_i,
  input wire logic pready_o,
  input wire logic pslverr_o
);

  // a response only inside an access phase
  ready_in_access: assert property (
    @(posedge clk) disable iff (rst_i) pready_o |-> psel_i && penable_i
  ) else $error("pready_o high outside an APB access phase");

  err_with_ready: assert property (
    @(posedge clk) disable iff (rst_i) pslverr_o |-> pready_o
  ) else $error("pslverr_o high without pready_o");

  ready_one_cycle: assert property (
    @(posedge clk) disable iff (rst_i) pready_o |=> !pready_o
  ) else $error("pready_o high for two cycles in a row");

  // outputs cleared from the first reset edge on
  quiet_in_reset: assert property (
    @(posedge clk) rst_i |=> !pready_o && !pslverr_o
  ) else $error("APB response raised during reset");

endmodule

bind lsu_top lsu_top_chk u_chk (
  .clk       (clk),
  .rst_i     (rst_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_o  (pready_o),
  .pslverr_o (pslverr_o)
);

`default_nettype wire

// ==== test/lsu_top_tb.sv ====
// load/store unit testbench

`default_nettype none
`timescale 1ns/1ps

module lsu_top_tb
  import lsu_pkg::*;
();

  localparam logic [63:0] BASE_ADDR = 64'h8000_0000;
  localparam int          RAM_WORDS = 256;
  localparam logic [63:0] RAM_BYTES = 64'(RAM_WORDS * DWORD_BYTES);
  localparam int          TIMEOUT   = 20;

  logic        clk = 1'b0;
  logic        rst_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [63:0] paddr_i;
  dword_t      pwdata_i;
  logic [2:0]  funct3_i;
  dword_t      prdata_o;
  logic        pready_o;
  logic        pslverr_o;

  // byte image of the RAM as the stores leave it
  logic [7:0]  shadow [RAM_WORDS * DWORD_BYTES];
  logic        exp_err_q [$];
  dword_t      exp_data_q [$];
  int          seed = 27086;
  int          errors = 0;
  int          timeouts = 0;
  int          transfers = 0;

  always #20 clk = ~clk;

  lsu_top #(
    .BASE_ADDR (BASE_ADDR),
    .RAM_WORDS (RAM_WORDS)
  ) DUT (
    .clk       (clk),
    .rst_i     (rst_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .funct3_i  (funct3_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  task automatic check_rdata(input string name, input dword_t got, input dword_t exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic dword_t fill_word(input int unsigned i);
    return {i * 32'h9e37_79b9 + 32'h0123_4567, i ^ 32'hc3a5_5a3c};
  endfunction

  // expected load value from the shadow bytes
  function automatic dword_t load_ref(input logic [63:0] addr, input logic [2:0] f3);
    int     pos;
    int     nbytes;
    dword_t val;
    pos    = int'(addr - BASE_ADDR);
    nbytes = 1 << f3[1:0];
    val    = '0;
    for (int i = 0; i < nbytes; i++) begin
      val[8*i +: 8] = shadow[pos + i];
    end
    // signed codes copy the top loaded bit upward
    if (!f3[2] && val[8*nbytes-1]) begin
      for (int i = 8 * nbytes; i < 64; i++) begin
        val[i] = 1'b1;
      end
    end
    return val;
  endfunction

  function automatic logic in_window(input logic [63:0] addr, input logic write,
                                     input logic [2:0] f3);
    logic [63:0] last;
    logic        code_ok;
    code_ok = write ? (f3 <= 3'd3) : (f3 != 3'd7);
    last    = addr - BASE_ADDR + (64'd1 << f3[1:0]) - 64'd1;
    return code_ok && (addr >= BASE_ADDR) && (last < RAM_BYTES);
  endfunction

  task automatic finish_run();
    $display("%0d transfers, %0d errors, %0d timeouts", transfers, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // one APB transfer with its expected response queued up front
  task automatic apb_access(input logic write, input logic [63:0] addr,
                            input logic [2:0] f3, input dword_t wdata);
    logic ok;
    logic done;
    int   cycles;
    int   pos;
    // a hung bus takes no further transfers
    if (timeouts != 0) begin
      return;
    end
    ok  = in_window(addr, write, f3);
    pos = int'(addr - BASE_ADDR);
    exp_err_q.push_back(!ok);
    exp_data_q.push_back((ok && !write) ? load_ref(addr, f3) : '0);
    if (ok && write) begin
      for (int i = 0; i < (1 << f3[1:0]); i++) begin
        shadow[pos + i] = wdata[8*i +: 8];
      end
    end
    @(posedge clk);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    funct3_i  <= f3;
    @(posedge clk);
    penable_i <= 1'b1;
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      done = pready_o;
    end
    if (done) begin
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
    end else begin
      $display("timeout: pready_o stayed low for %0d cycles at address %h", TIMEOUT, addr);
      timeouts++;
    end
  endtask

  // compare on every completed transfer
  always @(posedge clk) begin
    if (psel_i && penable_i && pready_o) begin
      transfers++;
      if (exp_err_q.size() == 0) begin
        $display("a transfer completed with no expected response queued");
        errors++;
      end else begin
        check_err("pslverr_o", pslverr_o, exp_err_q.pop_front());
        check_rdata("prdata_o", prdata_o, exp_data_q.pop_front());
      end
    end
  end

  task automatic aligned_tests();
    int unsigned r;
    int unsigned off;
    logic [63:0] addr;
    for (int w = 0; w < 4; w++) begin
      for (int k = 0; k < 4; k++) begin
        r    = $random(seed);
        off  = (r / 256) % 8;
        off  = off - off % (1 << w);
        addr = BASE_ADDR + 64'((r % RAM_WORDS) * 8 + off);
        apb_access(1'b1, addr, 3'(w), {$random(seed), $random(seed)});
        apb_access(1'b0, addr, 3'(w), '0);
        if (w < 3) begin
          apb_access(1'b0, addr, 3'(w + 4), '0);
        end
      end
    end
  endtask

  // every access here spills into the next dword
  task automatic misaligned_tests();
    int unsigned r;
    int unsigned w;
    int unsigned nbytes;
    int unsigned off;
    logic [63:0] addr;
    for (int k = 0; k < 40; k++) begin
      r      = $random(seed);
      w      = 1 + (r / 4096) % 3;
      nbytes = 1 << w;
      off    = 9 - nbytes + (r / 65536) % (nbytes - 1);
      addr   = BASE_ADDR + 64'((r % (RAM_WORDS - 1)) * 8 + off);
      apb_access(1'b1, addr, 3'(w), {$random(seed), $random(seed)});
      apb_access(1'b0, addr, 3'(w), '0);
      apb_access(1'b0, addr, 3'((r >> 24) % 7), '0);
    end
  endtask

  task automatic extension_tests();
    logic [63:0] addr;
    dword_t      pattern [2];
    addr       = BASE_ADDR + 64'h105;
    pattern[0] = 64'h8182_8384_8586_8788;
    pattern[1] = 64'h7172_7374_7576_7778;
    for (int p = 0; p < 2; p++) begin
      apb_access(1'b1, addr, FUNCT3_LD, pattern[p]);
      for (int w = 0; w < 3; w++) begin
        apb_access(1'b0, addr, 3'(w), '0);
        apb_access(1'b0, addr, 3'(w + 4), '0);
      end
    end
  endtask

  task automatic neighbor_tests();
    logic [63:0] rb [6];
    rb = '{64'h1f8, 64'h200, 64'h208, 64'h308, 64'h310, 64'h418};
    apb_access(1'b1, BASE_ADDR + 64'h207, FUNCT3_LB, 64'h5a);
    apb_access(1'b1, BASE_ADDR + 64'h30f, FUNCT3_LH, 64'hbeef);
    apb_access(1'b1, BASE_ADDR + 64'h41a, FUNCT3_LW, 64'hcafe_f00d);
    for (int i = 0; i < 6; i++) begin
      apb_access(1'b0, BASE_ADDR + rb[i], FUNCT3_LD, '0);
    end
  endtask

  task automatic range_tests();
    apb_access(1'b0, BASE_ADDR - 64'd8, FUNCT3_LD, '0);
    apb_access(1'b1, BASE_ADDR - 64'd1, FUNCT3_LB, 64'hff);
    apb_access(1'b1, BASE_ADDR + RAM_BYTES, FUNCT3_LW, '1);
    apb_access(1'b1, BASE_ADDR + RAM_BYTES - 64'd4, FUNCT3_LD, '1);
    apb_access(1'b0, BASE_ADDR + RAM_BYTES - 64'd2, FUNCT3_LW, '0);
    apb_access(1'b0, BASE_ADDR, 3'b111, '0);
    apb_access(1'b1, BASE_ADDR, FUNCT3_LBU, '1);
    // both ends of the RAM still hold their old data
    apb_access(1'b0, BASE_ADDR, FUNCT3_LD, '0);
    apb_access(1'b0, BASE_ADDR + RAM_BYTES - 64'd8, FUNCT3_LD, '0);
  endtask

  initial begin
    rst_i     = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    funct3_i  = '0;
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);
    check_err("pready_o", pready_o, 1'b0);
    check_err("pslverr_o", pslverr_o, 1'b0);
    check_rdata("prdata_o", prdata_o, '0);
    for (int unsigned i = 0; i < RAM_WORDS; i++) begin
      apb_access(1'b1, BASE_ADDR + 64'(i * 8), FUNCT3_LD, fill_word(i));
    end
    aligned_tests();
    misaligned_tests();
    extension_tests();
    neighbor_tests();
    range_tests();
    repeat (2) @(posedge clk);
    if (exp_err_q.size() != 0) begin
      $display("%0d queued transfers never completed", exp_err_q.size());
      errors++;
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== lsu_top.f ====
src/lsu_pkg.sv
src/lsu_if.sv
src/dword_ram.sv
src/lsu_decode.sv
src/lsu_execute.sv
src/lsu_result.sv
src/lsu_top.sv
test/lsu_top_chk.sv
test/lsu_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the lsu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module lsu_top_tb \
  -Mdir obj_dir \
  -f lsu_top.f

out=$(./obj_dir/Vlsu_top_tb 2>&1) || {
  echo "$out"
  exit 1
}
echo "$out"

# pass only when the testbench printed the pass line
grep -qx "TEST PASS" <<< "$out"
